// File: aes_dec.f
+incdir+test
source/aes_dec_pkg.sv
source/aes_dec_fifo.sv
source/aes_key_expand.sv
source/aes_inv_round.sv
source/aes_dec_ctrl.sv
source/aes_dec_top.sv
test/tb_aes_dec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the aes_dec testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f aes_dec.f \
    --top-module tb_aes_dec \
    -o tb_aes_dec

./obj_dir/tb_aes_dec | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: source/aes_dec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module aes_dec_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req_empty,
    output logic                      req_pop,
    output logic                      in_credit,
    output logic                      key_start,
    input  wire logic                 key_done,
    output aes_dec_pkg::round_idx_t   round_sel,
    output logic                      state_load,
    output logic                      state_step,
    output logic                      final_round,
    input  wire logic                 res_full,
    output logic                      res_push,
    input  wire logic                 res_empty,
    output logic                      res_pop,
    input  wire logic                 out_credit
);

    typedef enum logic [1:0] {
        st_idle,
        st_expand,
        st_rounds,
        st_deliver
    } fsm_t;

    typedef logic [$clog2(aes_dec_pkg::out_depth+1)-1:0] cred_t;

    fsm_t                    fsm_q;
    aes_dec_pkg::round_idx_t round_q;
    cred_t                   out_cred;

    // ------------------------------
    // strobes
    // ------------------------------
    assign key_start   = (fsm_q == st_idle) && !req_empty;      // key taken from the head
    assign req_pop     = (fsm_q == st_expand) && key_done;      // head leaves with the load
    assign in_credit   = req_pop;
    assign state_load  = req_pop;
    assign state_step  = (fsm_q == st_rounds);
    assign final_round = state_step && (round_q == '0);
    assign round_sel   = round_q;
    assign res_push    = (fsm_q == st_deliver) && !res_full;
    assign res_pop     = !res_empty && (out_cred != '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fsm_q   <= st_idle;
            round_q <= '0;
        end
        else
        begin
            case (fsm_q)
                st_idle:
                begin
                    if (key_start)
                    begin
                        fsm_q   <= st_expand;
                        round_q <= aes_dec_pkg::round_idx_t'(aes_dec_pkg::num_rounds);
                    end
                end
                st_expand:
                begin
                    if (state_load)
                    begin
                        fsm_q   <= st_rounds;
                        round_q <= round_q - aes_dec_pkg::round_idx_t'(1);
                    end
                end
                st_rounds:
                begin
                    if (round_q == '0)
                    begin
                        fsm_q <= st_deliver;
                    end
                    else
                    begin
                        round_q <= round_q - aes_dec_pkg::round_idx_t'(1);
                    end
                end
                default:
                begin
                    if (res_push)
                    begin
                        fsm_q <= st_idle;    // holds result while full
                    end
                end
            endcase
        end
    end

    // ------------------------------
    // output credits
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_cred <= cred_t'(aes_dec_pkg::out_depth);
        end
        else
        begin
            out_cred <= out_cred + cred_t'(out_credit) - cred_t'(res_pop);
        end
    end

endmodule

`default_nettype wire

// File: source/aes_dec_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module aes_dec_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 2
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  push,
    input  wire item_t push_data,
    input  wire logic  pop,
    output item_t      pop_data,
    output logic       empty,
    output logic       full
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    item_t mem [depth];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    cnt_t  count;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;    // both or neither
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];    // head straight from storage
    assign empty    = (count == '0);
    assign full     = (count == cnt_t'(depth));

endmodule

`default_nettype wire

// File: source/aes_dec_pkg.sv
`default_nettype none

package aes_dec_pkg;

    // ------------------------------
    // sizes and types
    // ------------------------------
    localparam int block_w    = 128;
    localparam int num_rounds = 10;
    localparam int in_depth   = 2;    // upstream credits after reset
    localparam int out_depth  = 2;    // our output credits after reset
    localparam int round_w    = 4;

    typedef logic [block_w-1:0]   block_t;
    typedef logic [block_w-1:0]   round_key_t;
    typedef logic [round_w-1:0]   round_idx_t;
    typedef logic [2*block_w-1:0] dec_req_t;    // ciphertext on top, key below

    // ------------------------------
    // GF(2^8) arithmetic
    // ------------------------------
    function automatic logic [7:0] gf_mul2(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (8'h1b & {8{a[7]}});
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] x;
        acc = 8'h00;
        x   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc = acc ^ x;
            end
            x = gf_mul2(x);
        end
        return acc;
    endfunction

    // a^254, zero stays zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] p;
        p = a;
        for (int i = 0; i < 6; i++)
        begin
            p = gf_mul(gf_mul(p, p), a);    // a^3, a^7 ... a^127
        end
        return gf_mul(p, p);
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] b;
        b = gf_inv(a);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
            ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [7:0] inv_sbox(input logic [7:0] a);
        logic [7:0] b;
        b = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
        return gf_inv(b);
    endfunction

    function automatic logic [7:0] rcon(input round_idx_t idx);
        logic [7:0] rc;
        case (idx)
            4'd1:    rc = 8'h01;
            4'd2:    rc = 8'h02;
            4'd3:    rc = 8'h04;
            4'd4:    rc = 8'h08;
            4'd5:    rc = 8'h10;
            4'd6:    rc = 8'h20;
            4'd7:    rc = 8'h40;
            4'd8:    rc = 8'h80;
            4'd9:    rc = 8'h1b;
            4'd10:   rc = 8'h36;
            default: rc = 8'h00;
        endcase
        return rc;
    endfunction

    // bytes column by column, row r rotates right by r
    function automatic block_t inv_shift_rows(input block_t s);
        block_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                r[block_w-1 - 8*(4*c + row) -: 8] =
                    s[block_w-1 - 8*(4*((c - row + 4) % 4) + row) -: 8];
            end
        end
        return r;
    endfunction

    function automatic block_t inv_mix_columns(input block_t s);
        block_t     r;
        logic [7:0] b  [4];
        logic [7:0] m2 [4];
        logic [7:0] m4 [4];
        logic [7:0] m8 [4];
        for (int c = 0; c < 4; c++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                b[k]  = s[block_w-1 - 8*(4*c + k) -: 8];
                m2[k] = gf_mul2(b[k]);
                m4[k] = gf_mul2(m2[k]);
                m8[k] = gf_mul2(m4[k]);
            end
            for (int k = 0; k < 4; k++)
            begin
                r[block_w-1 - 8*(4*c + k) -: 8] = (m8[k] ^ m4[k] ^ m2[k])    // x0e
                    ^ (m8[(k+1)%4] ^ m2[(k+1)%4] ^ b[(k+1)%4])             // x0b
                    ^ (m8[(k+2)%4] ^ m4[(k+2)%4] ^ b[(k+2)%4])             // x0d
                    ^ (m8[(k+3)%4] ^ b[(k+3)%4]);                          // x09
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: source/aes_dec_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_dec_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                in_valid,
    input  wire aes_dec_pkg::block_t in_block,
    input  wire aes_dec_pkg::block_t in_key,
    output logic                     in_credit,
    output logic                     out_valid,
    output aes_dec_pkg::block_t      out_block,
    input  wire logic                out_credit
);

    aes_dec_pkg::dec_req_t   req_head;
    aes_dec_pkg::block_t     req_block;
    aes_dec_pkg::block_t     req_key;
    aes_dec_pkg::round_key_t round_key;
    aes_dec_pkg::round_idx_t round_sel;
    aes_dec_pkg::block_t     state;
    logic                    req_empty;
    logic                    req_pop;
    logic                    key_start;
    logic                    key_done;
    logic                    state_load;
    logic                    state_step;
    logic                    final_round;
    logic                    res_full;
    logic                    res_push;
    logic                    res_empty;
    logic                    res_pop;

    assign req_block = req_head[aes_dec_pkg::block_w +: aes_dec_pkg::block_w];
    assign req_key   = req_head[0 +: aes_dec_pkg::block_w];
    assign out_valid = res_pop;    // data is the result FIFO head

    aes_dec_fifo #(
        .item_t (aes_dec_pkg::dec_req_t),
        .depth  (aes_dec_pkg::in_depth)
    ) i_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data ({in_block, in_key}),
        .pop       (req_pop),
        .pop_data  (req_head),
        .empty     (req_empty),
        .full      ()
    );

    aes_key_expand i_key_expand (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (key_start),
        .key       (req_key),
        .round_sel (round_sel),
        .round_key (round_key),
        .key_done  (key_done)
    );

    aes_inv_round i_inv_round (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (state_load),
        .step        (state_step),
        .block_in    (req_block),
        .round_key   (round_key),
        .final_round (final_round),
        .state       (state)
    );

    aes_dec_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_empty   (req_empty),
        .req_pop     (req_pop),
        .in_credit   (in_credit),
        .key_start   (key_start),
        .key_done    (key_done),
        .round_sel   (round_sel),
        .state_load  (state_load),
        .state_step  (state_step),
        .final_round (final_round),
        .res_full    (res_full),
        .res_push    (res_push),
        .res_empty   (res_empty),
        .res_pop     (res_pop),
        .out_credit  (out_credit)
    );

    aes_dec_fifo #(
        .item_t (aes_dec_pkg::block_t),
        .depth  (aes_dec_pkg::out_depth)
    ) i_res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_push),
        .push_data (state),
        .pop       (res_pop),
        .pop_data  (out_block),
        .empty     (res_empty),
        .full      (res_full)
    );

endmodule

`default_nettype wire

// File: source/aes_inv_round.sv
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    load,
    input  wire logic                    step,
    input  wire aes_dec_pkg::block_t     block_in,
    input  wire aes_dec_pkg::round_key_t round_key,
    input  wire logic                    final_round,
    output aes_dec_pkg::block_t          state
);

    aes_dec_pkg::block_t shifted;
    aes_dec_pkg::block_t subbed;
    aes_dec_pkg::block_t keyed;
    aes_dec_pkg::block_t next_state;

    // ------------------------------
    // one inverse round
    // ------------------------------
    always_comb
    begin
        shifted = aes_dec_pkg::inv_shift_rows(state);
        for (int i = 0; i < aes_dec_pkg::block_w / 8; i++)
        begin
            subbed[8*i +: 8] = aes_dec_pkg::inv_sbox(shifted[8*i +: 8]);
        end
        keyed = subbed ^ round_key;
        if (final_round)
        begin
            next_state = keyed;    // last round has no mix
        end
        else
        begin
            next_state = aes_dec_pkg::inv_mix_columns(keyed);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= '0;
        end
        else if (load)
        begin
            state <= block_in ^ round_key;    // key of round 10
        end
        else if (step)
        begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: source/aes_key_expand.sv
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start,
    input  wire aes_dec_pkg::block_t     key,
    input  wire aes_dec_pkg::round_idx_t round_sel,
    output aes_dec_pkg::round_key_t      round_key,
    output logic                         key_done
);

    aes_dec_pkg::round_key_t  rk_mem [aes_dec_pkg::num_rounds+1];
    aes_dec_pkg::round_key_t  prev_key;
    aes_dec_pkg::round_key_t  next_key;
    aes_dec_pkg::round_idx_t  gen_idx;
    logic                     busy;
    logic [31:0]              rot_word;
    logic [31:0]              sub_word;
    logic [31:0]              nw0;
    logic [31:0]              nw1;
    logic [31:0]              nw2;
    logic [31:0]              nw3;

    // ------------------------------
    // next round key
    // ------------------------------
    always_comb
    begin
        rot_word = {prev_key[23:0], prev_key[31:24]};    // last column rotated
        for (int i = 0; i < 4; i++)
        begin
            sub_word[8*i +: 8] = aes_dec_pkg::sbox(rot_word[8*i +: 8]);
        end
        nw0      = prev_key[127:96] ^ sub_word ^ {aes_dec_pkg::rcon(gen_idx), 24'h0};
        nw1      = prev_key[95:64] ^ nw0;
        nw2      = prev_key[63:32] ^ nw1;
        nw3      = prev_key[31:0] ^ nw2;
        next_key = {nw0, nw1, nw2, nw3};
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rk_mem[0] <= key;
            prev_key  <= key;
        end
        else if (busy)
        begin
            rk_mem[gen_idx] <= next_key;
            prev_key        <= next_key;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            gen_idx  <= '0;
            key_done <= 1'b0;
        end
        else if (start)
        begin
            busy     <= 1'b1;
            gen_idx  <= aes_dec_pkg::round_idx_t'(1);
            key_done <= 1'b0;    // old schedule no longer valid
        end
        else if (busy)
        begin
            if (gen_idx == aes_dec_pkg::round_idx_t'(aes_dec_pkg::num_rounds))
            begin
                busy     <= 1'b0;
                key_done <= 1'b1;
            end
            else
            begin
                gen_idx <= gen_idx + aes_dec_pkg::round_idx_t'(1);
            end
        end
    end

    assign round_key = rk_mem[round_sel];

endmodule

`default_nettype wire

// File: test/tb_aes_dec_vectors.svh
`ifndef TB_AES_DEC_VECTORS_SVH
`define TB_AES_DEC_VECTORS_SVH

// one entry per index: name, key, ciphertext, expected plaintext
// entry 0 is FIPS-197 C.1, entries 1 to 4 are SP 800-38A ECB-AES128

localparam int num_vectors = 5;

string vec_name [num_vectors] = '{
    "fips197_c1",
    "sp800_38a_ecb_blk1",
    "sp800_38a_ecb_blk2",
    "sp800_38a_ecb_blk3",
    "sp800_38a_ecb_blk4"
};

aes_dec_pkg::block_t vec_key [num_vectors] = '{
    128'h000102030405060708090a0b0c0d0e0f,
    128'h2b7e151628aed2a6abf7158809cf4f3c,
    128'h2b7e151628aed2a6abf7158809cf4f3c,
    128'h2b7e151628aed2a6abf7158809cf4f3c,
    128'h2b7e151628aed2a6abf7158809cf4f3c
};

aes_dec_pkg::block_t vec_cipher [num_vectors] = '{
    128'h69c4e0d86a7b0430d8cdb78070b4c55a,
    128'h3ad77bb40d7a3660a89ecaf32466ef97,
    128'hf5d3d58503b9699de785895a96fdbaaf,
    128'h43b1cd7f598ece23881b00e3ed030688,
    128'h7b0c785e27e8ad3f8223207104725dd4
};

aes_dec_pkg::block_t vec_plain [num_vectors] = '{
    128'h00112233445566778899aabbccddeeff,
    128'h6bc1bee22e409f96e93d7e117393172a,
    128'hae2d8a571e03ac9c9eb76fac45af8e51,
    128'h30c81c46a35ce411e5fbc1191a0a52ef,
    128'hf69f2445df4f9b17ad2b417be66c3710
};

`endif

// File: test/tb_aes_dec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aes_dec;

    localparam int credit_prompt = 0;
    localparam int credit_hold   = 1;
    localparam int credit_random = 2;
    localparam int wait_limit    = 400;    // cycles per wait
    localparam int hold_cycles   = 200;

    `include "tb_aes_dec_vectors.svh"

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    aes_dec_pkg::block_t in_block;
    aes_dec_pkg::block_t in_key;
    logic                in_credit;
    logic                out_valid;
    aes_dec_pkg::block_t out_block;
    logic                out_credit    = 1'b0;

    integer              seed;
    int                  credit_mode   = credit_prompt;
    int                  in_credits    = aes_dec_pkg::in_depth;    // upstream side
    int                  credit_pulses = 0;
    int                  blocks_sent   = 0;
    int                  received      = 0;
    int                  returned      = 0;
    int                  check_count   = 0;
    int                  error_count   = 0;
    aes_dec_pkg::block_t exp_queue [$];
    string               name_queue [$];

    aes_dec_top i_aes_dec_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_block   (in_block),
        .in_key     (in_key),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_block  (out_block),
        .out_credit (out_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------
    // downstream credit model
    // ------------------------------
    always @(posedge clk)
    begin : credit_return
        logic [31:0] rand_val;
        rand_val = $random(seed);
        if (rst_n && (received > returned) &&
            (credit_mode == credit_prompt ||
             (credit_mode == credit_random && rand_val[1:0] == 2'b00)))
        begin
            out_credit <= 1'b1;
            returned++;
        end
        else
        begin
            out_credit <= 1'b0;
        end
    end

    // sampled mid-cycle when outputs are settled
    always @(negedge clk)
    begin : output_monitor
        aes_dec_pkg::block_t exp_val;
        string               exp_name;
        if (rst_n && in_credit)
        begin
            in_credits++;
            credit_pulses++;
            check_value("input credits held", 128'(1),
                        128'(in_credits <= aes_dec_pkg::in_depth));
        end
        if (rst_n && out_valid)
        begin
            received++;
            check_value("output credits respected", 128'(1),
                        128'(received - returned <= aes_dec_pkg::out_depth));
            if (exp_queue.size() == 0)
            begin
                error_count++;
                $display("result %h arrived with no block outstanding", out_block);
            end
            else
            begin
                exp_val  = exp_queue.pop_front();
                exp_name = name_queue.pop_front();
                check_value(exp_name, exp_val, out_block);
            end
        end
    end

    task automatic check_reset_outputs();
        check_value("reset out_valid", 128'(0), 128'(out_valid));
        check_value("reset in_credit", 128'(0), 128'(in_credit));
    endtask

    task automatic send_block(input int idx);
        int waited;
        waited = 0;
        @(posedge clk);
        while (in_credits == 0 && waited < wait_limit)
        begin
            in_valid <= 1'b0;    // bubble while no credit
            @(posedge clk);
            waited++;
        end
        if (in_credits == 0)
        begin
            error_count++;
            in_valid <= 1'b0;
            $display("timeout: no input credit came back for block %s", vec_name[idx]);
        end
        else
        begin
            in_valid <= 1'b1;
            in_block <= vec_cipher[idx];
            in_key   <= vec_key[idx];
            in_credits--;
            blocks_sent++;
            exp_queue.push_back(vec_plain[idx]);
            name_queue.push_back(vec_name[idx]);
        end
    endtask

    task automatic end_burst();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_results(input int target, input string what);
        int waited;
        waited = 0;
        while (received < target && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (received < target)
        begin
            error_count++;
            $display("timeout: %s, only %0d of %0d results arrived", what, received, target);
        end
    endtask

    task automatic wait_credits_back(input string what);
        int waited;
        waited = 0;
        while (returned < received && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (returned < received)
        begin
            error_count++;
            $display("timeout: %s, output credits were not all returned", what);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial
    begin : main
        int base;
        seed     = 32'h2854_af3f;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_block = '0;
        in_key   = '0;

        repeat (3)
        begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs();    // first cycle out of reset

        send_block(0);
        end_burst();
        wait_results(1, "single block");
        wait_credits_back("single block");

        for (int i = 0; i < num_vectors; i++)
        begin
            send_block(i);    // key changes after entry 0
        end
        end_burst();
        wait_results(1 + num_vectors, "stream");
        wait_credits_back("stream");

        // downstream stalls and then returns credits at random
        credit_mode = credit_hold;
        base        = received;
        for (int i = 0; i < num_vectors; i++)
        begin
            send_block(i);
        end
        end_burst();
        repeat (hold_cycles) @(posedge clk);
        check_value("results while credits withheld", 128'(1),
                    128'(received - base <= aes_dec_pkg::out_depth));
        credit_mode = credit_random;
        wait_results(1 + 2 * num_vectors, "back-pressure");
        wait_credits_back("back-pressure");

        check_value("blocks still pending", 128'(0), 128'(exp_queue.size()));
        check_value("input credit pulses", 128'(blocks_sent), 128'(credit_pulses));

        $display("blocks sent %0d, results %0d, checks %0d, errors %0d",
                 blocks_sent, received, check_count, error_count);
        if (error_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
